/* verilog.f */
+incdir+bench
common/riscv_mext_pkg.sv
design/riscv_mext_decode.sv
riscv_divider/riscv_divider.sv
design/riscv_multiplier.sv
design/riscv_mext_result.sv
design/riscv_mext_unit.sv
bench/riscv_mext_tb.sv

/* bench/riscv_mext_model.svh */
`ifndef RISCV_MEXT_MODEL_SVH
`define RISCV_MEXT_MODEL_SVH

// expected M-extension results worked out from the ISA rules

function automatic logic [63:0] sext_word(input logic [31:0] v);
	return {{32{v[31]}}, v};
endfunction

// word forms exist only for MUL and the divider ops
function automatic logic illegal_form(input logic [2:0] f3, input logic word);
	return word && !(f3 == MEXT_MUL || f3[2]);
endfunction

function automatic logic [63:0] divide_long(input logic [2:0] f3, input logic [63:0] a,
	input logic [63:0] b);
	logic signed [63:0] sa;
	logic signed [63:0] sb;
	logic [63:0]        q;
	logic [63:0]        r;
	sa = a;
	sb = b;
	if (b == '0) begin
		q = '1;
		r = a;
	end else if (f3 == MEXT_DIVU || f3 == MEXT_REMU) begin
		q = a / b;
		r = a % b;
	end else if (a == 64'h8000_0000_0000_0000 && b == '1) begin
		q = a;   // signed overflow
		r = '0;
	end else begin
		q = sa / sb;   // truncates toward zero
		r = sa % sb;   // sign of the dividend
	end
	return f3[1] ? r : q;
endfunction

// 32-bit divide as DIVW/DIVUW/REMW/REMUW define it
function automatic logic [63:0] divide_word(input logic [2:0] f3, input logic [31:0] a,
	input logic [31:0] b);
	logic signed [31:0] sa;
	logic signed [31:0] sb;
	logic [31:0]        q;
	logic [31:0]        r;
	sa = a;
	sb = b;
	if (b == '0) begin
		q = '1;
		r = a;
	end else if (f3 == MEXT_DIVU || f3 == MEXT_REMU) begin
		q = a / b;
		r = a % b;
	end else if (a == 32'h8000_0000 && b == '1) begin
		q = a;
		r = '0;
	end else begin
		q = sa / sb;
		r = sa % sb;
	end
	return sext_word(f3[1] ? r : q);
endfunction

function automatic logic [63:0] multiply_long(input logic [2:0] f3, input logic [63:0] a,
	input logic [63:0] b);
	logic signed [127:0] pa;
	logic signed [127:0] pb;
	logic signed [127:0] p;
	if (f3 == MEXT_MULHU)
		pa = {64'b0, a};
	else
		pa = $signed(a);
	if (f3 == MEXT_MULH)
		pb = $signed(b);
	else
		pb = {64'b0, b};   // MULHSU takes rs2 as unsigned
	p = pa * pb;
	return (f3 == MEXT_MUL) ? p[63:0] : p[127:64];
endfunction

function automatic logic [63:0] expected_result(input logic [2:0] f3, input logic word,
	input logic [63:0] a, input logic [63:0] b);
	logic [31:0] low_product;
	if (illegal_form(f3, word))
		return '0;
	if (word && f3 == MEXT_MUL) begin
		low_product = a[31:0] * b[31:0];
		return sext_word(low_product);
	end
	if (word)
		return divide_word(f3, a[31:0], b[31:0]);
	if (f3[2])
		return divide_long(f3, a, b);
	return multiply_long(f3, a, b);
endfunction

`endif

/* bench/riscv_mext_tb.sv */
`timescale 1ns/1ps

module riscv_mext_tb;

	import riscv_mext_pkg::*;

	`include "riscv_mext_model.svh"

	localparam int N_RANDOM   = 2000;
	localparam int MAX_CYCLES = 3000;   // reset, ~100 directed, random ops, gaps, drain

	localparam logic [63:0] MOST_NEG = 64'h8000_0000_0000_0000;

	logic            i_riscv_clk;
	logic            i_reset;
	logic            i_riscv_mext_valid;
	logic [2:0]      i_riscv_mext_funct3;
	logic            i_riscv_mext_word;
	logic [XLEN-1:0] i_riscv_mext_rs1data;
	logic [XLEN-1:0] i_riscv_mext_rs2data;
	logic            o_riscv_mext_valid;
	logic            o_riscv_mext_illegal;
	logic [XLEN-1:0] o_riscv_mext_result;

	mext_resp_t exp_q[$];   // expected responses in issue order
	string      name_q[$];
	mext_resp_t exp_now;    // expectation for the response now on the outputs
	string      name_now;
	logic       have_exp;
	int         cycle_count;
	int         issued;
	int         checked;

	logic [63:0] extremes [4] = '{64'd0, 64'd1, 64'hFFFF_FFFF_FFFF_FFFF, MOST_NEG};

	riscv_mext_unit i_dut (
		.i_riscv_clk          (i_riscv_clk),
		.i_reset              (i_reset),
		.i_riscv_mext_valid   (i_riscv_mext_valid),
		.i_riscv_mext_funct3  (i_riscv_mext_funct3),
		.i_riscv_mext_word    (i_riscv_mext_word),
		.i_riscv_mext_rs1data (i_riscv_mext_rs1data),
		.i_riscv_mext_rs2data (i_riscv_mext_rs2data),
		.o_riscv_mext_valid   (o_riscv_mext_valid),
		.o_riscv_mext_illegal (o_riscv_mext_illegal),
		.o_riscv_mext_result  (o_riscv_mext_result)
	);

	always #5 i_riscv_clk = ~i_riscv_clk;

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic issue_op(input string name, input logic [2:0] f3, input logic word,
		input logic [63:0] a, input logic [63:0] b);
		mext_resp_t exp;
		exp.valid   = 1'b1;
		exp.illegal = illegal_form(f3, word);
		exp.result  = expected_result(f3, word, a, b);
		@(posedge i_riscv_clk);
		i_riscv_mext_valid   <= 1'b1;
		i_riscv_mext_funct3  <= f3;
		i_riscv_mext_word    <= word;
		i_riscv_mext_rs1data <= a;
		i_riscv_mext_rs2data <= b;
		exp_q.push_back(exp);
		name_q.push_back(name);
		issued++;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge i_riscv_clk);
			i_riscv_mext_valid   <= 1'b0;
			i_riscv_mext_rs1data <= {$urandom, $urandom};   // junk while idle
		end
	endtask

	task automatic run_divider_cases();
		logic [63:0] dividends [2];
		logic [63:0] divisors [2];
		dividends = '{64'd17, -64'sd17};
		divisors  = '{64'd5, -64'sd5};
		issue_op("div_by_zero", MEXT_DIV, 1'b0, 64'd123, 64'd0);
		issue_op("divu_by_zero", MEXT_DIVU, 1'b0, 64'd123, 64'd0);
		issue_op("rem_by_zero", MEXT_REM, 1'b0, -64'sd5, 64'd0);
		issue_op("remu_by_zero", MEXT_REMU, 1'b0, 64'd77, 64'd0);
		issue_op("div_overflow", MEXT_DIV, 1'b0, MOST_NEG, '1);
		issue_op("rem_overflow", MEXT_REM, 1'b0, MOST_NEG, '1);
		issue_op("divu_big_divisor", MEXT_DIVU, 1'b0, '1, MOST_NEG);
		issue_op("remu_big_divisor", MEXT_REMU, 1'b0, '1, MOST_NEG);
		issue_op("divu_big_divisor", MEXT_DIVU, 1'b0, MOST_NEG + 64'd5,
			64'hFFFF_FFFF_FFFF_FFFE);
		issue_op("remu_big_divisor", MEXT_REMU, 1'b0, 64'hFFFF_FFFF_FFFF_FFFD,
			64'hFFFF_FFFF_FFFF_FFFE);
		issue_op("divu_big_divisor", MEXT_DIVU, 1'b0, 64'd5, MOST_NEG);
		for (int i = 0; i < 2; i++) begin
			for (int j = 0; j < 2; j++) begin
				issue_op("div_signs", MEXT_DIV, 1'b0, dividends[i], divisors[j]);
				issue_op("rem_signs", MEXT_REM, 1'b0, dividends[i], divisors[j]);
			end
		end
	endtask

	task automatic run_multiplier_cases();
		for (int k = 0; k < 4; k++) begin   // MUL, MULH, MULHSU, MULHU
			for (int i = 0; i < 4; i++) begin
				for (int j = 0; j < 4; j++) begin
					issue_op("mul_extremes", 3'(k), 1'b0, extremes[i], extremes[j]);
				end
			end
		end
	endtask

	// upper operand halves carry garbage the word ops must ignore
	task automatic run_word_cases();
		issue_op("mulw", MEXT_MUL, 1'b1, {32'hDEAD_BEEF, 32'h7FFF_FFFF},
			{32'h1234_5678, 32'h0000_0002});
		issue_op("mulw", MEXT_MUL, 1'b1, {32'hCAFE_F00D, 32'h8000_0000},
			{32'h0F0F_0F0F, 32'hFFFF_FFFF});
		issue_op("divw_overflow", MEXT_DIV, 1'b1, {32'h1111_1111, 32'h8000_0000},
			{32'h2222_2222, 32'hFFFF_FFFF});
		issue_op("remw_overflow", MEXT_REM, 1'b1, {32'h1111_1111, 32'h8000_0000},
			{32'h2222_2222, 32'hFFFF_FFFF});
		issue_op("divw_by_zero", MEXT_DIV, 1'b1, {32'h3333_3333, 32'h0000_0042},
			{32'h4444_4444, 32'h0000_0000});
		issue_op("divuw_by_zero", MEXT_DIVU, 1'b1, {32'h3333_3333, 32'h0000_0042},
			{32'h4444_4444, 32'h0000_0000});
		issue_op("remw_by_zero", MEXT_REM, 1'b1, {32'h9999_9999, 32'hFFFF_FF00},
			{32'hAAAA_AAAA, 32'h0000_0000});
		issue_op("remuw_by_zero", MEXT_REMU, 1'b1, {32'h9999_9999, 32'h8000_0001},
			{32'hAAAA_AAAA, 32'h0000_0000});
		issue_op("divuw", MEXT_DIVU, 1'b1, {32'h5555_5555, 32'hFFFF_FFF0},
			{32'h6666_6666, 32'h0000_0003});
		issue_op("remuw", MEXT_REMU, 1'b1, {32'h5555_5555, 32'hFFFF_FFF0},
			{32'h6666_6666, 32'h0000_0003});
		issue_op("divw", MEXT_DIV, 1'b1, {32'h7777_7777, 32'hFFFF_FFF9},
			{32'h8888_8888, 32'h0000_0002});
		issue_op("remw", MEXT_REM, 1'b1, {32'h7777_7777, 32'hFFFF_FFF9},
			{32'h8888_8888, 32'h0000_0002});
	endtask

	task automatic run_illegal_cases();
		issue_op("mulhw_illegal", MEXT_MULH, 1'b1, '1, MOST_NEG);
		issue_op("mulhsuw_illegal", MEXT_MULHSU, 1'b1, MOST_NEG, 64'd3);
		issue_op("mulhuw_illegal", MEXT_MULHU, 1'b1, '1, '1);
	endtask

	task automatic run_random_traffic();
		logic [63:0] a;
		logic [63:0] b;
		logic [2:0]  f3;
		logic        word;
		for (int n = 0; n < N_RANDOM; n++) begin
			f3   = 3'($urandom_range(7));
			word = ($urandom_range(3) == 0);
			a    = {$urandom, $urandom};
			b    = {$urandom, $urandom};
			case ($urandom_range(15))   // steer some ops into divider corners
				0: b = '0;
				1: b = {60'd0, b[3:0]};
				2: begin
					a = MOST_NEG;
					b = '1;
				end
				default: ;
			endcase
			issue_op("random", f3, word, a, b);
			if ($urandom_range(7) == 0)
				idle_cycles($urandom_range(2, 1));
		end
	endtask

	// head of the queue is lined up half a cycle before the check
	always @(negedge i_riscv_clk) begin
		if (o_riscv_mext_valid === 1'b1 && exp_q.size() > 0) begin
			exp_now  = exp_q.pop_front();
			name_now = name_q.pop_front();
			have_exp = 1'b1;
			checked++;
		end else begin
			have_exp = 1'b0;
		end
	end

	always @(posedge i_riscv_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
			stop_with_failure($sformatf("timeout after %0d cycles, %0d of %0d responses seen",
				MAX_CYCLES, checked, issued));
	end

	a_reset_values: assert property (@(posedge i_riscv_clk)
		(cycle_count >= 1 && $past(i_reset)) |->
		(!o_riscv_mext_valid && !o_riscv_mext_illegal && o_riscv_mext_result == '0))
		else stop_with_failure($sformatf(
			"MISMATCH test=reset expected=valid/illegal/result 0/0/0 actual=%b/%b/%h",
			$sampled(o_riscv_mext_valid), $sampled(o_riscv_mext_illegal),
			$sampled(o_riscv_mext_result)));

	a_valid_latency: assert property (@(posedge i_riscv_clk) disable iff (i_reset)
		o_riscv_mext_valid == $past(i_riscv_mext_valid))
		else stop_with_failure("response valid did not follow the request valid by one cycle");

	a_response_expected: assert property (@(posedge i_riscv_clk) disable iff (i_reset)
		o_riscv_mext_valid |-> have_exp)
		else stop_with_failure("a response appeared with no operation outstanding");

	a_result: assert property (@(posedge i_riscv_clk) disable iff (i_reset)
		(o_riscv_mext_valid && have_exp) |-> (o_riscv_mext_result == exp_now.result))
		else stop_with_failure($sformatf("MISMATCH test=%s expected=%h actual=%h",
			name_now, exp_now.result, $sampled(o_riscv_mext_result)));

	a_illegal: assert property (@(posedge i_riscv_clk) disable iff (i_reset)
		(o_riscv_mext_valid && have_exp) |-> (o_riscv_mext_illegal == exp_now.illegal))
		else stop_with_failure($sformatf("MISMATCH test=%s expected=illegal %b actual=illegal %b",
			name_now, exp_now.illegal, $sampled(o_riscv_mext_illegal)));

	initial begin
		void'($urandom(8));
		i_riscv_clk          = 1'b0;
		i_reset              = 1'b1;
		i_riscv_mext_valid   = 1'b0;
		i_riscv_mext_funct3  = 3'b000;
		i_riscv_mext_word    = 1'b0;
		i_riscv_mext_rs1data = '0;
		i_riscv_mext_rs2data = '0;
		have_exp             = 1'b0;
		cycle_count          = 0;
		issued               = 0;
		checked              = 0;

		repeat (5) @(posedge i_riscv_clk);
		i_reset <= 1'b0;

		run_divider_cases();
		run_multiplier_cases();
		run_word_cases();
		run_illegal_cases();
		idle_cycles(2);
		run_random_traffic();
		idle_cycles(1);

		wait (exp_q.size() == 0);
		repeat (2) @(posedge i_riscv_clk);   // last check lands on the next edge
		$display("=== PASS ===");
		$finish;
	end

endmodule

/* design/riscv_mext_unit.sv */
`timescale 1ns/1ps

module riscv_mext_unit (
	input  logic                            i_riscv_clk,
	input  logic                            i_reset,
	input  logic                            i_riscv_mext_valid,
	input  logic [2:0]                      i_riscv_mext_funct3,
	input  logic                            i_riscv_mext_word,
	input  logic [riscv_mext_pkg::XLEN-1:0] i_riscv_mext_rs1data,
	input  logic [riscv_mext_pkg::XLEN-1:0] i_riscv_mext_rs2data,
	output logic                            o_riscv_mext_valid,
	output logic                            o_riscv_mext_illegal,
	output logic [riscv_mext_pkg::XLEN-1:0] o_riscv_mext_result
);

	import riscv_mext_pkg::*;

	mext_req_t       req;
	mext_resp_t      resp;
	logic [XLEN-1:0] mul_result;
	logic [XLEN-1:0] div_result;

	riscv_mext_decode u_decode (
		.i_riscv_mext_valid   (i_riscv_mext_valid),
		.i_riscv_mext_funct3  (i_riscv_mext_funct3),
		.i_riscv_mext_word    (i_riscv_mext_word),
		.i_riscv_mext_rs1data (i_riscv_mext_rs1data),
		.i_riscv_mext_rs2data (i_riscv_mext_rs2data),
		.o_riscv_mext_req     (req)
	);

	riscv_multiplier u_multiplier (
		.i_riscv_mul_op      (req.op),
		.i_riscv_mul_rs1data (req.rs1),
		.i_riscv_mul_rs2data (req.rs2),
		.o_riscv_mul_result  (mul_result)
	);

	riscv_divider u_divider (
		.i_riscv_div_divctrl (req.op),
		.i_riscv_div_rs1data (req.rs1),
		.i_riscv_div_rs2data (req.rs2),
		.o_riscv_div_result  (div_result)
	);

	riscv_mext_result u_result (
		.i_riscv_clk        (i_riscv_clk),
		.i_reset            (i_reset),
		.i_riscv_mext_req   (req),
		.i_riscv_mul_result (mul_result),
		.i_riscv_div_result (div_result),
		.o_riscv_mext_resp  (resp)
	);

	// response fields out to the pipeline
	assign o_riscv_mext_valid   = resp.valid;
	assign o_riscv_mext_illegal = resp.illegal;
	assign o_riscv_mext_result  = resp.result;

endmodule

/* design/riscv_mext_result.sv */
`timescale 1ns/1ps

module riscv_mext_result (
	input  logic                            i_riscv_clk,
	input  logic                            i_reset,
	input  riscv_mext_pkg::mext_req_t       i_riscv_mext_req,
	input  logic [riscv_mext_pkg::XLEN-1:0] i_riscv_mul_result,
	input  logic [riscv_mext_pkg::XLEN-1:0] i_riscv_div_result,
	output riscv_mext_pkg::mext_resp_t      o_riscv_mext_resp
);

	import riscv_mext_pkg::*;

	logic [XLEN-1:0] sel_result;
	logic [XLEN-1:0] next_result;

	always_comb begin
		if (i_riscv_mext_req.op[OP_DIV_BIT])
			sel_result = i_riscv_div_result;
		else
			sel_result = i_riscv_mul_result;

		if (i_riscv_mext_req.illegal)
			next_result = '0;
		else if (i_riscv_mext_req.word)
			// *W ops return the low word sign-extended
			next_result = {{(XLEN-WLEN){sel_result[WLEN-1]}}, sel_result[WLEN-1:0]};
		else
			next_result = sel_result;
	end

	always_ff @(posedge i_riscv_clk) begin
		if (i_reset) begin
			o_riscv_mext_resp.valid   <= 1'b0;
			o_riscv_mext_resp.illegal <= 1'b0;
			o_riscv_mext_resp.result  <= '0;
		end else begin
			o_riscv_mext_resp.valid <= i_riscv_mext_req.valid;
			if (i_riscv_mext_req.valid) begin   // hold last result when idle
				o_riscv_mext_resp.illegal <= i_riscv_mext_req.illegal;
				o_riscv_mext_resp.result  <= next_result;
			end
		end
	end

	// fixed one-cycle latency, no stalls
	a_one_cycle: assert property (@(posedge i_riscv_clk) disable iff (i_reset)
		!$past(i_reset) |-> (o_riscv_mext_resp.valid == $past(i_riscv_mext_req.valid)))
		else $error("result stage: response valid does not follow request valid");

endmodule

/* design/riscv_multiplier.sv */
`timescale 1ns/1ps

module riscv_multiplier (
	input  riscv_mext_pkg::mext_op_e        i_riscv_mul_op,
	input  logic [riscv_mext_pkg::XLEN-1:0] i_riscv_mul_rs1data,
	input  logic [riscv_mext_pkg::XLEN-1:0] i_riscv_mul_rs2data,
	output logic [riscv_mext_pkg::XLEN-1:0] o_riscv_mul_result
);

	import riscv_mext_pkg::*;

	logic              rs1_signed;
	logic              rs2_signed;
	logic [2*XLEN-1:0] rs1_ext;
	logic [2*XLEN-1:0] rs2_ext;
	logic [2*XLEN-1:0] product;   // modulo 2^128, exact for both halves

	// operand extension per opcode
	always_comb begin
		rs1_signed = i_riscv_mul_op inside {MEXT_MULH, MEXT_MULHSU};
		rs2_signed = (i_riscv_mul_op == MEXT_MULH);

		if (rs1_signed)
			rs1_ext = {{XLEN{i_riscv_mul_rs1data[XLEN-1]}}, i_riscv_mul_rs1data};
		else
			rs1_ext = {{XLEN{1'b0}}, i_riscv_mul_rs1data};

		if (rs2_signed)
			rs2_ext = {{XLEN{i_riscv_mul_rs2data[XLEN-1]}}, i_riscv_mul_rs2data};
		else
			rs2_ext = {{XLEN{1'b0}}, i_riscv_mul_rs2data};
	end

	always_comb begin
		product = rs1_ext * rs2_ext;   // low 128 bits of the extended product

		case (i_riscv_mul_op)
			MEXT_MUL: begin
				o_riscv_mul_result = product[XLEN-1:0];   // sign-agnostic
			end
			MEXT_MULH, MEXT_MULHSU, MEXT_MULHU: begin
				o_riscv_mul_result = product[2*XLEN-1:XLEN];
			end
			default: begin
				o_riscv_mul_result = '0;   // divider ops
			end
		endcase
	end

endmodule

/* riscv_divider/riscv_divider.sv */
`timescale 1ns/1ps

module riscv_divider (
	input  riscv_mext_pkg::mext_op_e        i_riscv_div_divctrl,
	input  logic [riscv_mext_pkg::XLEN-1:0] i_riscv_div_rs1data,
	input  logic [riscv_mext_pkg::XLEN-1:0] i_riscv_div_rs2data,
	output logic [riscv_mext_pkg::XLEN-1:0] o_riscv_div_result
);

	import riscv_mext_pkg::*;

	logic            is_signed;
	logic            div_by_zero;
	logic            overflow;
	logic            quo_neg;     // result signs for the signed forms
	logic            rem_neg;
	logic [XLEN-1:0] dividend;    // magnitudes fed to the loop
	logic [XLEN-1:0] divisor;
	logic [XLEN-1:0] quotient;
	logic [XLEN:0]   remainder;   // extra bit so divisors of 2^63 and up fit
	logic [XLEN+1:0] trial;
	logic [XLEN-1:0] quo_signed;
	logic [XLEN-1:0] rem_signed;

	// operand magnitudes
	always_comb begin
		is_signed = !i_riscv_div_divctrl[OP_UNS_BIT];

		if (is_signed && i_riscv_div_rs1data[XLEN-1])
			dividend = ~i_riscv_div_rs1data + 1'b1;
		else
			dividend = i_riscv_div_rs1data;

		if (is_signed && i_riscv_div_rs2data[XLEN-1])
			divisor = ~i_riscv_div_rs2data + 1'b1;
		else
			divisor = i_riscv_div_rs2data;
	end

	// restoring shift-subtract, one quotient bit per step
	always_comb begin
		quotient  = dividend;   // shifts out dividend bits, shifts in quotient bits
		remainder = '0;
		trial     = '0;
		for (int i = 0; i < XLEN; i++) begin
			remainder = {remainder[XLEN-1:0], quotient[XLEN-1]};
			quotient  = {quotient[XLEN-2:0], 1'b0};
			trial     = {1'b0, remainder} - {2'b00, divisor};
			if (trial[XLEN+1]) begin
				quotient[0] = 1'b0;   // negative, keep old remainder
			end else begin
				quotient[0] = 1'b1;
				remainder   = trial[XLEN:0];
			end
		end
	end

	// sign fixup and architectural corner cases
	always_comb begin
		div_by_zero = (i_riscv_div_rs2data == '0);
		overflow    = is_signed && (i_riscv_div_rs1data == XLEN_MIN) &&
			(i_riscv_div_rs2data == '1);

		quo_neg = i_riscv_div_rs1data[XLEN-1] ^ i_riscv_div_rs2data[XLEN-1];
		rem_neg = i_riscv_div_rs1data[XLEN-1];   // remainder follows the dividend

		quo_signed = quo_neg ? (~quotient + 1'b1) : quotient;
		rem_signed = rem_neg ? (~remainder[XLEN-1:0] + 1'b1) : remainder[XLEN-1:0];

		case (i_riscv_div_divctrl)
			MEXT_DIV: begin
				if (div_by_zero)
					o_riscv_div_result = '1;
				else if (overflow)
					o_riscv_div_result = i_riscv_div_rs1data;
				else
					o_riscv_div_result = quo_signed;
			end
			MEXT_DIVU: begin
				if (div_by_zero)
					o_riscv_div_result = '1;
				else
					o_riscv_div_result = quotient;
			end
			MEXT_REM: begin
				if (div_by_zero)
					o_riscv_div_result = i_riscv_div_rs1data;
				else if (overflow)
					o_riscv_div_result = '0;
				else
					o_riscv_div_result = rem_signed;
			end
			MEXT_REMU: begin
				if (div_by_zero)
					o_riscv_div_result = i_riscv_div_rs1data;
				else
					o_riscv_div_result = remainder[XLEN-1:0];
			end
			default: o_riscv_div_result = '0;   // multiplier opcodes
		endcase
	end

	// divide-by-zero results seen at the output
	always_comb begin
		if (i_riscv_div_divctrl == MEXT_DIV && i_riscv_div_rs2data == '0) begin
			a_div_zero: assert final (o_riscv_div_result == '1)
				else $error("divider: DIV by zero did not return all ones");
		end
		if (i_riscv_div_divctrl == MEXT_REMU && i_riscv_div_rs2data == '0) begin
			a_remu_zero: assert final (o_riscv_div_result == i_riscv_div_rs1data)
				else $error("divider: REMU by zero did not return the dividend");
		end
	end

endmodule

/* design/riscv_mext_decode.sv */
`timescale 1ns/1ps

module riscv_mext_decode (
	input  logic                         i_riscv_mext_valid,
	input  logic [2:0]                   i_riscv_mext_funct3,
	input  logic                         i_riscv_mext_word,
	input  logic [riscv_mext_pkg::XLEN-1:0] i_riscv_mext_rs1data,
	input  logic [riscv_mext_pkg::XLEN-1:0] i_riscv_mext_rs2data,
	output riscv_mext_pkg::mext_req_t    o_riscv_mext_req
);

	import riscv_mext_pkg::*;

	mext_op_e op;
	logic     word_high_mul;   // MULHW and friends do not exist
	logic     word_zext;       // DIVUW/REMUW take zero-extended operands

	always_comb begin
		op            = mext_op_e'(i_riscv_mext_funct3);
		word_high_mul = i_riscv_mext_word && (op inside {MEXT_MULH, MEXT_MULHSU, MEXT_MULHU});
		word_zext     = op inside {MEXT_DIVU, MEXT_REMU};

		o_riscv_mext_req.valid   = i_riscv_mext_valid;
		o_riscv_mext_req.op      = op;
		o_riscv_mext_req.word    = i_riscv_mext_word;
		o_riscv_mext_req.illegal = word_high_mul;

		if (!i_riscv_mext_word) begin
			o_riscv_mext_req.rs1 = i_riscv_mext_rs1data;
			o_riscv_mext_req.rs2 = i_riscv_mext_rs2data;
		end else if (word_zext) begin
			o_riscv_mext_req.rs1 = {{(XLEN-WLEN){1'b0}}, i_riscv_mext_rs1data[WLEN-1:0]};
			o_riscv_mext_req.rs2 = {{(XLEN-WLEN){1'b0}}, i_riscv_mext_rs2data[WLEN-1:0]};
		end else begin
			// signed word ops run as 64-bit ops on sign-extended halves
			o_riscv_mext_req.rs1 = {{(XLEN-WLEN){i_riscv_mext_rs1data[WLEN-1]}},
				i_riscv_mext_rs1data[WLEN-1:0]};
			o_riscv_mext_req.rs2 = {{(XLEN-WLEN){i_riscv_mext_rs2data[WLEN-1]}},
				i_riscv_mext_rs2data[WLEN-1:0]};
		end
	end

	// a valid request must carry a known opcode into the datapath
	always_comb begin
		if (o_riscv_mext_req.valid === 1'b1) begin
			a_op_known: assert final (!$isunknown(o_riscv_mext_req.op))
				else $error("decode: valid request with unknown opcode");
		end
	end

endmodule

/* common/riscv_mext_pkg.sv */
package riscv_mext_pkg;

	localparam int XLEN = 64;
	localparam int WLEN = 32;   // width of the *W forms

	localparam int OP_DIV_BIT = 2;   // op bit that routes to the divider
	localparam int OP_UNS_BIT = 0;   // op bit set for unsigned variants

	localparam logic [XLEN-1:0] XLEN_MIN = {1'b1, {(XLEN-1){1'b0}}};   // most negative value

	// encoding matches funct3 of the OP/OP-32 major opcodes
	typedef enum logic [2:0] {
		MEXT_MUL    = 3'b000,
		MEXT_MULH   = 3'b001,
		MEXT_MULHSU = 3'b010,
		MEXT_MULHU  = 3'b011,
		MEXT_DIV    = 3'b100,
		MEXT_DIVU   = 3'b101,
		MEXT_REM    = 3'b110,
		MEXT_REMU   = 3'b111
	} mext_op_e;

	// decoded request, operands already extended for word ops
	typedef struct packed {
		logic            valid;
		mext_op_e        op;
		logic            word;      // result gets sign-extended from bit 31
		logic            illegal;   // word form of a high-half multiply
		logic [XLEN-1:0] rs1;
		logic [XLEN-1:0] rs2;
	} mext_req_t;

	// registered response
	typedef struct packed {
		logic            valid;
		logic            illegal;
		logic [XLEN-1:0] result;
	} mext_resp_t;

endpackage
